//--- common/uartPkg.sv
// register map, frame codes and reset values for the serial port
// plus the buffer word union and the shared parity rule
package uartPkg;

	// register addresses
	localparam logic [1:0] AdrTrb  = 2'd0;	// transmit / receive buffer
	localparam logic [1:0] AdrStat = 2'd1;
	localparam logic [1:0] AdrCmd  = 2'd2;
	localparam logic [1:0] AdrCtrl = 2'd3;

	localparam int DataW = 32;	// bus width
	localparam int DivW  = 24;	// baud divisor width

	// small divisor keeps bit times short
	localparam logic [DivW-1:0] DivReset = 24'd4;

	// parity control codes, cmd bits 7:5
	localparam logic [2:0] ParNone  = 3'b000;
	localparam logic [2:0] ParOdd   = 3'b001;
	localparam logic [2:0] ParEven  = 3'b011;
	localparam logic [2:0] ParMark  = 3'b101;	// forced one
	localparam logic [2:0] ParSpace = 3'b111;	// forced zero

	// status byte layout
	localparam int StatParBit     = 0;
	localparam int StatFrmBit     = 1;
	localparam int StatOvrBit     = 2;
	localparam int StatRxFullBit  = 3;
	localparam int StatTxEmptyBit = 4;
	localparam int StatIrqBit     = 7;

	// buffer write word, seen as a tx byte or as a new divisor
	typedef union packed {
		struct packed {
			logic [DataW-9:0] pad;
			logic [7:0]       txByte;
		} byteView;
		struct packed {
			logic [DataW-DivW-1:0] pad;
			logic [DivW-1:0]       divisor;
		} divView;
	} trbWord_u;

	// parity bit for the masked data of one frame
	function automatic logic parityBit(input logic [7:0] data, input logic [2:0] ctrl);
		logic bitOut;
		case (ctrl)
			ParOdd:   bitOut = ~^data;	// total ones odd
			ParEven:  bitOut = ^data;
			ParMark:  bitOut = 1'b1;
			ParSpace: bitOut = 1'b0;
			default:  bitOut = 1'b0;	// no parity bit sent
		endcase
		return bitOut;
	endfunction

endpackage

//--- verilog/baudGen.sv
`timescale 1ns/1ps
// divisor counter giving the 16x baud tick
module baudGen (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic [uartPkg::DivW-1:0] divisor_i,
	output logic                     tick_o
);
	import uartPkg::*;

	logic [DivW-1:0] count;	// runs 1 .. divisor

	// one tick per divisor clocks
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			count  <= DivW'(1);
			tick_o <= 1'b0;
		end else if (count >= divisor_i) begin	// also catches a shrunk divisor
			count  <= DivW'(1);
			tick_o <= 1'b1;
		end else begin
			count  <= count + 1'b1;
			tick_o <= 1'b0;
		end
	end

endmodule

//--- verilog/uartRegs.sv
`timescale 1ns/1ps
// bus ack, register file, read mux, rx status flags and irq
module uartRegs (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  logic                      cs_i,
	input  logic                      cyc_i,
	input  logic                      stb_i,
	input  logic                      we_i,
	input  logic [3:0]                sel_i,
	input  logic [1:0]                adr_i,
	input  logic [uartPkg::DataW-1:0] dat_i,
	output logic                      ack_o,
	output logic [uartPkg::DataW-1:0] dat_o,
	output logic                      irq_o,
	output logic [uartPkg::DivW-1:0]  divisor_o,
	output logic [7:0]                txData_o,
	output logic                      txLoad_o,
	output logic [1:0]                wordLen_o,
	output logic [2:0]                parityCtrl_o,
	output logic                      twoStop_o,
	output logic                      loopback_o,
	input  logic                      txEmpty_i,
	input  logic [7:0]                rxData_i,
	input  logic                      rxValid_i,
	input  logic                      parityErr_i,
	input  logic                      frameErr_i
);
	import uartPkg::*;

	logic             req;		// cs & cyc & stb
	logic             reqDone;	// acked, waiting for stb to drop
	logic             wrStb;
	logic             rdTrb;	// rx buffer read, clears rxFull
	logic             rxTake;	// byte accepted into rxBuf
	logic [DataW-1:0] cmdReg;
	logic [DataW-1:0] ctrlReg;
	logic [DataW-1:0] rdMux;
	logic             accessCD;
	logic             rxIe;
	logic             rxFull;
	logic             parErr;
	logic             frmErr;
	logic             ovrErr;
	logic [7:0]       rxBuf;
	logic [7:0]       statByte;
	trbWord_u         wrWord;

	assign req      = cs_i & cyc_i & stb_i;
	assign wrWord   = dat_i;
	assign accessCD = ctrlReg[DataW-1];
	assign wrStb    = ack_o & we_i;	// lands at the edge closing ack
	assign rdTrb    = ack_o & ~we_i & (adr_i == AdrTrb) & ~accessCD;
	assign rxTake   = rxValid_i & (~rxFull | rdTrb);

	// frame settings
	assign parityCtrl_o = cmdReg[7:5];
	assign loopback_o   = cmdReg[4];
	assign wordLen_o    = ctrlReg[6:5];	// 0=8 .. 3=5 bits
	assign twoStop_o    = ctrlReg[7];

	// ------------------------------------------------
	// bus handshake
	// ------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o   <= 1'b0;
			reqDone <= 1'b0;
		end else begin
			ack_o   <= req & ~ack_o & ~reqDone;	// single cycle ack
			reqDone <= req & (reqDone | ack_o);	// rearm once req drops
		end
	end

	always_comb begin
		statByte                 = '0;
		statByte[StatParBit]     = parErr;
		statByte[StatFrmBit]     = frmErr;
		statByte[StatOvrBit]     = ovrErr;
		statByte[StatRxFullBit]  = rxFull;
		statByte[StatTxEmptyBit] = txEmpty_i;
		statByte[StatIrqBit]     = irq_o;
	end

	always_comb begin
		case (adr_i)
			AdrTrb:  rdMux = accessCD ? DataW'(divisor_o) : DataW'(rxBuf);
			AdrStat: rdMux = DataW'(statByte);
			AdrCmd:  rdMux = cmdReg;
			AdrCtrl: rdMux = ctrlReg;
			default: rdMux = '0;
		endcase
	end

	// read data captured as ack rises, held through the ack cycle
	always_ff @(posedge clk_i) begin
		if (req & ~ack_o & ~reqDone)
			dat_o <= rdMux;
	end

	// ------------------------------------------------
	// control registers
	// ------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cmdReg    <= '0;
			ctrlReg   <= '0;
			rxIe      <= 1'b0;
			divisor_o <= DivReset;
			txLoad_o  <= 1'b0;
		end else begin
			txLoad_o <= 1'b0;
			if (wrStb) begin
				case (adr_i)
					AdrTrb:
						if (accessCD) begin
							divisor_o          <= wrWord.divView.divisor;
							ctrlReg[DataW-1]   <= 1'b0;	// one shot divisor access
						end else if (txEmpty_i) begin
							txLoad_o <= 1'b1;	// dropped while tx busy
						end
					AdrCmd: begin
						for (int b = 0; b < 4; b++)
							if (sel_i[b])
								cmdReg[b*8 +: 8] <= dat_i[b*8 +: 8];
						if (sel_i[0])
							rxIe <= ~dat_i[1];	// bit stores the inverse
					end
					AdrCtrl:
						for (int b = 0; b < 4; b++)
							if (sel_i[b])
								ctrlReg[b*8 +: 8] <= dat_i[b*8 +: 8];
					default: ;
				endcase
			end
		end
	end

	// tx byte payload
	always_ff @(posedge clk_i) begin
		if (wrStb && adr_i == AdrTrb)
			txData_o <= wrWord.byteView.txByte;
	end

	// ------------------------------------------------
	// receive status and interrupt
	// ------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rxFull <= 1'b0;
			parErr <= 1'b0;
			frmErr <= 1'b0;
			ovrErr <= 1'b0;
			irq_o  <= 1'b0;
		end else begin
			irq_o <= rxIe & rxFull;
			if (rxTake) begin
				rxFull <= 1'b1;
				parErr <= parErr | parityErr_i;
				frmErr <= frmErr | frameErr_i;
			end else if (rdTrb) begin
				rxFull <= 1'b0;
			end
			if (rxValid_i & rxFull & ~rdTrb)
				ovrErr <= 1'b1;	// new byte lost
			// status write clears the sticky errors
			if (wrStb && adr_i == AdrStat) begin
				parErr <= 1'b0;
				frmErr <= 1'b0;
				ovrErr <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rxTake)
			rxBuf <= rxData_i;
	end

endmodule

//--- tx/uartTx.sv
`timescale 1ns/1ps
// transmit holding register and frame serializer
module uartTx (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       tick_i,
	input  logic [7:0] txData_i,
	input  logic       txLoad_i,
	input  logic [1:0] wordLen_i,
	input  logic [2:0] parityCtrl_i,
	input  logic       twoStop_i,
	output logic       txEmpty_o,
	output logic       txd_o
);
	import uartPkg::*;

	logic [7:0]  holdByte;
	logic [7:0]  dataMasked;
	logic        pending;	// byte waiting for a tick
	logic        active;	// frame on the line
	logic        parEn;
	logic        startFrame;
	logic        nextBit;
	logic [3:0]  tickCnt;	// 16 ticks per bit
	logic [3:0]  bitsLeft;
	logic [3:0]  dataBits;
	logic [3:0]  frameLen;
	logic [11:0] frame;		// start + 8 data + parity + 2 stop max
	logic [11:0] shiftReg;

	assign dataBits   = 4'd8 - {2'b00, wordLen_i};
	assign parEn      = parityCtrl_i != ParNone;
	assign dataMasked = holdByte & (8'hff >> wordLen_i);
	assign frameLen   = 4'd2 + dataBits + {3'b000, parEn} + {3'b000, twoStop_i};
	assign startFrame = tick_i & ~active & pending;
	assign nextBit    = tick_i & active & (tickCnt == 4'd15);
	assign txEmpty_o  = ~(pending | active);

	// ------------------------------------------------
	// frame image, lsb goes out first
	// ------------------------------------------------
	always_comb begin
		frame    = '1;	// stop bits and idle fill
		frame[0] = 1'b0;	// start bit
		for (int i = 0; i < 8; i++)
			if (i < dataBits)
				frame[i+1] = dataMasked[i];
		if (parEn)
			frame[dataBits+1] = parityBit(dataMasked, parityCtrl_i);
	end

	always_ff @(posedge clk_i) begin
		if (txLoad_i)
			holdByte <= txData_i;
	end

	always_ff @(posedge clk_i) begin
		if (startFrame)
			shiftReg <= frame;
		else if (nextBit)
			shiftReg <= {1'b1, shiftReg[11:1]};
	end

	// bit timing and line driver
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pending  <= 1'b0;
			active   <= 1'b0;
			tickCnt  <= '0;
			bitsLeft <= '0;
			txd_o    <= 1'b1;	// line idles high
		end else begin
			if (txLoad_i)
				pending <= 1'b1;
			if (startFrame) begin
				pending  <= 1'b0;
				active   <= 1'b1;
				tickCnt  <= '0;
				bitsLeft <= frameLen - 4'd1;
				txd_o    <= frame[0];
			end else if (tick_i && active) begin
				tickCnt <= tickCnt + 4'd1;
				if (nextBit) begin
					if (bitsLeft == 4'd0) begin
						active <= 1'b0;	// last stop bit done
						txd_o  <= 1'b1;
					end else begin
						bitsLeft <= bitsLeft - 4'd1;
						txd_o    <= shiftReg[1];
					end
				end
			end
		end
	end

endmodule

//--- rx/uartRx.sv
`timescale 1ns/1ps
// receive line sync, start detect, mid-bit sampler,
// deserializer with parity and stop checks
module uartRx (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       tick_i,
	input  logic       rxd_i,
	input  logic [1:0] wordLen_i,
	input  logic [2:0] parityCtrl_i,
	input  logic       twoStop_i,
	output logic [7:0] rxData_o,
	output logic       rxValid_o,
	output logic       parityErr_o,
	output logic       frameErr_o
);
	import uartPkg::*;

	logic [1:0] syncReg;	// two flop synchronizer
	logic       rxLine;
	logic       busy;		// inside a frame
	logic       holdOff;	// second stop bit time
	logic       parEn;
	logic       parRx;
	logic       sampleNow;
	logic [3:0] tickCnt;
	logic [3:0] bitIdx;		// 0 = start bit
	logic [3:0] dataBits;
	logic [3:0] parIdx;
	logic [3:0] stopIdx;
	logic [7:0] shiftReg;
	logic [7:0] aligned;

	assign rxLine    = syncReg[1];
	assign dataBits  = 4'd8 - {2'b00, wordLen_i};
	assign parEn     = parityCtrl_i != ParNone;
	assign parIdx    = dataBits + 4'd1;
	assign stopIdx   = parIdx + {3'b000, parEn};
	assign sampleNow = tick_i & busy & (tickCnt == 4'd7);	// 8 ticks into the bit
	assign aligned   = shiftReg >> wordLen_i;	// data enters at the msb

	// ------------------------------------------------
	// frame sequencing
	// ------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			syncReg     <= 2'b11;
			busy        <= 1'b0;
			holdOff     <= 1'b0;
			tickCnt     <= '0;
			bitIdx      <= '0;
			rxValid_o   <= 1'b0;
			parityErr_o <= 1'b0;
			frameErr_o  <= 1'b0;
		end else begin
			syncReg     <= {syncReg[0], rxd_i};
			rxValid_o   <= 1'b0;
			parityErr_o <= 1'b0;
			frameErr_o  <= 1'b0;
			if (tick_i && (busy || holdOff))
				tickCnt <= tickCnt + 4'd1;
			// the tick seeing the line low is tick 0 of the start bit
			if (tick_i && !busy && !holdOff && !rxLine) begin
				busy    <= 1'b1;
				tickCnt <= '0;
				bitIdx  <= '0;
			end
			if (sampleNow) begin
				bitIdx <= bitIdx + 4'd1;
				if (bitIdx == 4'd0 && rxLine)
					busy <= 1'b0;	// glitch, not a start bit
				if (bitIdx == stopIdx) begin
					busy        <= 1'b0;
					holdOff     <= twoStop_i;
					rxValid_o   <= 1'b1;
					parityErr_o <= parEn & (parRx != parityBit(aligned, parityCtrl_i));
					frameErr_o  <= ~rxLine;	// first stop must be high
				end
			end
			if (holdOff && tick_i && tickCnt == 4'd7)
				holdOff <= 1'b0;	// mid second stop, ready again
		end
	end

	// data path
	always_ff @(posedge clk_i) begin
		if (sampleNow) begin
			if (bitIdx >= 4'd1 && bitIdx <= dataBits)
				shiftReg <= {rxLine, shiftReg[7:1]};
			if (parEn && bitIdx == parIdx)
				parRx <= rxLine;
			if (bitIdx == stopIdx)
				rxData_o <= aligned;
		end
	end

endmodule

//--- verilog/uartTop.sv
`timescale 1ns/1ps
// serial port top: registers, baud generator, tx, rx, loopback
module uartTop (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        cs_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [3:0]  sel_i,
	input  logic [1:0]  adr_i,
	input  logic [31:0] dat_i,
	output logic        ack_o,
	output logic [31:0] dat_o,
	output logic        irq_o,
	input  logic        rxd_i,
	output logic        txd_o
);
	import uartPkg::*;

	logic [DivW-1:0] divisor;
	logic            tick;		// 16x baud
	logic [7:0]      txData;
	logic            txLoad;
	logic            txEmpty;
	logic            txLine;	// serializer output
	logic            rxLine;	// line into the receiver
	logic [7:0]      rxData;
	logic            rxValid;
	logic            parityErr;
	logic            frameErr;
	logic [1:0]      wordLen;
	logic [2:0]      parityCtrl;
	logic            twoStop;
	logic            loopback;

	// loopback turns tx back into rx, pin idles high
	assign rxLine = loopback ? txLine : rxd_i;
	assign txd_o  = loopback ? 1'b1 : txLine;

	uartRegs uartRegs_i (
		.clk_i(clk_i), .rst_i(rst_i), .cs_i(cs_i), .cyc_i(cyc_i), .stb_i(stb_i),
		.we_i(we_i), .sel_i(sel_i), .adr_i(adr_i), .dat_i(dat_i),
		.ack_o(ack_o), .dat_o(dat_o), .irq_o(irq_o),
		.divisor_o(divisor), .txData_o(txData), .txLoad_o(txLoad),
		.wordLen_o(wordLen), .parityCtrl_o(parityCtrl), .twoStop_o(twoStop),
		.loopback_o(loopback), .txEmpty_i(txEmpty), .rxData_i(rxData),
		.rxValid_i(rxValid), .parityErr_i(parityErr), .frameErr_i(frameErr)
	);

	baudGen baudGen_i (.clk_i(clk_i), .rst_i(rst_i), .divisor_i(divisor), .tick_o(tick));

	uartTx uartTx_i (
		.clk_i(clk_i), .rst_i(rst_i), .tick_i(tick), .txData_i(txData), .txLoad_i(txLoad),
		.wordLen_i(wordLen), .parityCtrl_i(parityCtrl), .twoStop_i(twoStop),
		.txEmpty_o(txEmpty), .txd_o(txLine)
	);

	uartRx uartRx_i (
		.clk_i(clk_i), .rst_i(rst_i), .tick_i(tick), .rxd_i(rxLine),
		.wordLen_i(wordLen), .parityCtrl_i(parityCtrl), .twoStop_i(twoStop),
		.rxData_o(rxData), .rxValid_o(rxValid),
		.parityErr_o(parityErr), .frameErr_o(frameErr)
	);

endmodule

//--- dv/uartProperties.sv
`timescale 1ns/1ps
// bound checks on bus ack length, irq timing and the loopback line
module uartProperties (
	input logic clk_i,
	input logic rst_i,
	input logic ack_i,
	input logic irq_i,
	input logic rxIe_i,
	input logic rxFull_i,
	input logic loopback_i,
	input logic txd_i
);

	// single cycle ack
	ackPulse: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i)
		else $error("ack_o stayed high for more than one cycle");

	irqTiming: assert property (@(posedge clk_i) disable iff (rst_i)
		irq_i == $past(rxIe_i & rxFull_i))
		else $error("irq_o does not follow rxIe and rxFull by one cycle");

	// pin parked high while tx is turned back to rx
	loopIdle: assert property (@(posedge clk_i) disable iff (rst_i) loopback_i |-> txd_i)
		else $error("txd_o left idle level during loopback");

endmodule

bind uartTop uartProperties uartProps_i (
	.clk_i(clk_i), .rst_i(rst_i), .ack_i(ack_o), .irq_i(irq_o),
	.rxIe_i(uartRegs_i.rxIe), .rxFull_i(uartRegs_i.rxFull),
	.loopback_i(loopback), .txd_i(txd_o)
);

//--- dv/uartTb.sv
`timescale 1ns/1ps
// serial port testbench: bus tasks, line model, frame table, checks, watchdog
module uartTb;
	import uartPkg::*;

	localparam int DivTest = 6;		// divisor loaded by the divisor test
	localparam int BitClk  = 16 * DivTest;	// clocks per bit
	localparam int NumRows = 9;
	localparam logic [1:0] CorNone = 2'd0;
	localparam logic [1:0] CorPar  = 2'd1;	// flipped parity bit
	localparam logic [1:0] CorStop = 2'd2;	// first stop bit low
	localparam longint WatchNs = longint'(NumRows * 2 * 12 * BitClk + 80 * BitClk) * 8;

	typedef struct packed {
		logic [1:0] wordLen;	// 0=8 .. 3=5 bits
		logic [2:0] parCtrl;
		logic       twoStop;
		logic [1:0] corrupt;
		logic       loop;		// loopback, else external line
		logic       expPar;
		logic       expFrm;
	} frameRow_t;

	// ------------------------------------------------
	// frame table
	// ------------------------------------------------
	localparam frameRow_t Rows [NumRows] = '{
		{2'd0, ParNone,  1'b0, CorNone, 1'b1, 1'b0, 1'b0},	// 8N1 loopback
		{2'd1, ParOdd,   1'b1, CorNone, 1'b1, 1'b0, 1'b0},
		{2'd3, ParEven,  1'b0, CorNone, 1'b1, 1'b0, 1'b0},
		{2'd0, ParEven,  1'b0, CorNone, 1'b0, 1'b0, 1'b0},	// external from here
		{2'd2, ParOdd,   1'b1, CorNone, 1'b0, 1'b0, 1'b0},
		{2'd1, ParMark,  1'b0, CorNone, 1'b0, 1'b0, 1'b0},
		{2'd0, ParSpace, 1'b1, CorNone, 1'b0, 1'b0, 1'b0},
		{2'd0, ParEven,  1'b0, CorPar,  1'b0, 1'b1, 1'b0},
		{2'd3, ParNone,  1'b0, CorStop, 1'b0, 1'b0, 1'b1}
	};

	logic        clk;
	logic        rst;
	logic        cs;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [3:0]  sel;
	logic [1:0]  adr;
	logic [31:0] datIn;
	logic        ack;
	logic [31:0] datOut;
	logic        irq;
	logic        rxd;
	logic        txd;
	logic [15:0] lfsr;
	int          errors;
	int          testsRun;
	int          testsFailed;

	uartTop uartTop_i (
		.clk_i(clk), .rst_i(rst), .cs_i(cs), .cyc_i(cyc), .stb_i(stb), .we_i(we),
		.sel_i(sel), .adr_i(adr), .dat_i(datIn), .ack_o(ack), .dat_o(datOut),
		.irq_o(irq), .rxd_i(rxd), .txd_o(txd)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic randomByte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsrNext(lfsr);	// one step per bit
			b    = {lfsr[0], b[7:1]};
		end
	endtask

	// odd and even count the data ones together with the parity bit
	function automatic logic wantParity(input logic [7:0] d, input logic [2:0] p);
		case (p)
			ParOdd:  return ~(^d);
			ParEven: return ^d;
			ParMark: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic int frameLen(input frameRow_t r);
		return 2 + (8 - int'(r.wordLen)) + int'(r.parCtrl != ParNone) + int'(r.twoStop);
	endfunction

	// line image, bit 0 first, stop bits and fill high
	function automatic logic [11:0] buildFrame(input logic [7:0] d, input frameRow_t r);
		logic [11:0] f;
		int          nb;
		nb   = 8 - int'(r.wordLen);
		f    = '1;
		f[0] = 1'b0;
		for (int i = 0; i < nb; i++)
			f[i+1] = d[i];
		if (r.parCtrl != ParNone)
			f[nb+1] = wantParity(d & (8'hff >> r.wordLen), r.parCtrl);
		return f;
	endfunction

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic endTest(input string name, input int errBase);
		testsRun++;
		if (errors == errBase) begin
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: FAILED with %0d errors", name, errors - errBase);
		end
	endtask

	// ends 1 ns past a rising edge
	task automatic waitClocks(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// ------------------------------------------------
	// bus master
	// ------------------------------------------------
	task automatic busXfer(input logic wr, input logic [1:0] a, input logic [3:0] s,
			input logic [31:0] d, output logic [31:0] q);
		int n;
		waitClocks(1);	// request low for a cycle first
		n = 0;
		{cs, cyc, stb, we} = {3'b111, wr};
		adr   = a;
		sel   = s;
		datIn = d;
		do begin
			waitClocks(1);
			n++;
		end while (!ack && n < 16);
		assert (ack) else begin
			$display("%0t ns: bus request got no ack", $time);
			errors++;
		end
		q = datOut;	// valid during ack
		waitClocks(1);	// write lands at this edge
		{cs, cyc, stb, we} = 4'b0000;
	endtask

	task automatic busWrite(input logic [1:0] a, input logic [3:0] s, input logic [31:0] d);
		logic [31:0] unused;
		busXfer(1'b1, a, s, d, unused);
	endtask

	task automatic busRead(input logic [1:0] a, output logic [31:0] q);
		busXfer(1'b0, a, 4'hf, 32'd0, q);
	endtask

	// frame format in ctrl, parity, loopback and irq enable in cmd
	task automatic setFrame(input frameRow_t r, input logic ie);
		busWrite(AdrCtrl, 4'b0001, {24'd0, r.twoStop, r.wordLen, 5'd0});
		busWrite(AdrCmd, 4'b0001, {24'd0, r.parCtrl, r.loop, 2'b00, ~ie, 1'b0});
	endtask

	// poll status until a bit sets, idle line checked in loopback
	task automatic waitStat(input int bitPos, input logic loopIdle, input string what);
		logic [31:0] st;
		int          n;
		n = 0;
		do begin
			busRead(AdrStat, st);
			if (loopIdle)
				checkVal("txd_o", 32'(txd), 32'd1);
			n++;
		end while (!st[bitPos] && n < 400);
		assert (st[bitPos]) else begin
			$display("%0t ns: status never showed %s", $time, what);
			errors++;
		end
	endtask

	// ------------------------------------------------
	// line partner
	// ------------------------------------------------
	task automatic sendFrame(input logic [11:0] f, input int len, input int cut);
		for (int i = 0; i < len; i++) begin
			rxd = f[i];
			waitClocks(i == cut ? 10 * DivTest : BitClk);	// cut bit released early
		end
		rxd = 1'b1;
	endtask

	task automatic captureTx(input int len, output logic [11:0] got);
		int n;
		got = '1;
		n   = 0;
		while (txd && n < 4 * BitClk) begin
			waitClocks(1);
			n++;
		end
		assert (!txd) else begin
			$display("%0t ns: no start bit appeared on txd_o", $time);
			errors++;
		end
		waitClocks(8 * DivTest);	// middle of start bit
		for (int i = 0; i < len; i++) begin
			if (i > 0)
				waitClocks(BitClk);
			got[i] = txd;
		end
	endtask

	initial begin
		#(WatchNs);
		$display("%0t ns: watchdog expired before the tests finished", $time);
		$display("Something failed");
		$finish;
	end

	initial begin
		frameRow_t   row;
		trbWord_u    w;
		logic [7:0]  b;
		logic [7:0]  b2;
		logic [7:0]  mask;
		logic [11:0] f;
		logic [11:0] got;
		logic [31:0] q;
		logic        extra;
		int          errBase;
		int          cut;
		int          nb;
		{cs, cyc, stb, we} = 4'b0000;
		sel         = '0;
		adr         = '0;
		datIn       = '0;
		rxd         = 1'b1;	// idle line
		rst         = 1'b1;
		lfsr        = 16'd60140;
		errors      = 0;
		testsRun    = 0;
		testsFailed = 0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		errBase = errors;
		busRead(AdrStat, q);
		checkVal("stat", q, 32'(1 << StatTxEmptyBit));
		busRead(AdrCtrl, q);
		checkVal("ctrl", q, 32'd0);
		busRead(AdrCmd, q);
		checkVal("cmd", q, 32'd0);
		checkVal("irq_o", 32'(irq), 32'd0);
		checkVal("txd_o", 32'(txd), 32'd1);
		endTest("reset values", errBase);

		// divisor through the buffer word, then a byte at the new rate
		errBase = errors;
		w = '0;
		w.divView.divisor = DivW'(DivTest);
		busWrite(AdrCtrl, 4'b1000, 32'h8000_0000);
		busWrite(AdrTrb, 4'b1111, w);
		busWrite(AdrCtrl, 4'b1000, 32'h8000_0000);
		busRead(AdrTrb, q);
		checkVal("divisor", q, 32'(DivTest));
		busWrite(AdrCtrl, 4'b1000, 32'd0);
		setFrame(Rows[0], 1'b0);
		randomByte(b);
		busWrite(AdrTrb, 4'b1111, {24'd0, b});
		waitStat(StatRxFullBit, 1'b1, "rx full");
		busRead(AdrTrb, q);
		checkVal("rx buffer", q, {24'd0, b});
		waitStat(StatTxEmptyBit, 1'b1, "tx empty");
		endTest("divisor access", errBase);

		for (int r = 0; r < NumRows; r++) begin
			errBase = errors;
			row     = Rows[r];
			nb      = 8 - int'(row.wordLen);
			mask    = 8'hff >> row.wordLen;
			setFrame(row, 1'b0);
			randomByte(b);
			f = buildFrame(b, row);
			busWrite(AdrTrb, 4'b1111, {24'd0, b});
			if (!row.loop) begin
				captureTx(frameLen(row), got);
				checkVal("txd_o frame", 32'(got), 32'(f));
				cut = -1;
				if (row.corrupt == CorPar)
					f[nb+1] = ~f[nb+1];
				if (row.corrupt == CorStop) begin
					cut    = nb + 1 + int'(row.parCtrl != ParNone);
					f[cut] = 1'b0;
				end
				sendFrame(f, frameLen(row), cut);
			end
			waitStat(StatRxFullBit, row.loop, "rx full");
			busRead(AdrStat, q);
			checkVal("stat errors", 32'(q[2:0]), 32'({1'b0, row.expFrm, row.expPar}));
			busRead(AdrTrb, q);
			checkVal("rx data", q, 32'(b & mask));
			if (row.expPar || row.expFrm) begin
				busWrite(AdrStat, 4'b0001, 32'd0);	// clears sticky errors
				busRead(AdrStat, q);
				checkVal("stat errors cleared", 32'(q[2:0]), 32'd0);
			end
			waitStat(StatTxEmptyBit, row.loop, "tx empty");
			endTest($sformatf("frame row %0d", r), errBase);
		end

		errBase = errors;
		setFrame(Rows[0], 1'b1);
		randomByte(b);
		busWrite(AdrTrb, 4'b1111, {24'd0, b});
		waitStat(StatRxFullBit, 1'b1, "rx full");
		waitClocks(1);
		checkVal("irq_o", 32'(irq), 32'd1);
		busRead(AdrTrb, q);
		checkVal("rx buffer", q, {24'd0, b});
		waitClocks(2);	// rxFull then irq register
		checkVal("irq_o", 32'(irq), 32'd0);
		waitStat(StatTxEmptyBit, 1'b1, "tx empty");
		endTest("receive irq", errBase);

		// second byte lands on a full buffer
		errBase = errors;
		setFrame(Rows[0], 1'b0);
		randomByte(b);
		randomByte(b2);
		busWrite(AdrTrb, 4'b1111, {24'd0, b});
		waitStat(StatRxFullBit, 1'b1, "rx full");
		waitStat(StatTxEmptyBit, 1'b1, "tx empty");
		busWrite(AdrTrb, 4'b1111, {24'd0, b2});
		waitStat(StatOvrBit, 1'b1, "overrun");
		busRead(AdrTrb, q);
		checkVal("rx buffer", q, {24'd0, b});
		busWrite(AdrStat, 4'b0001, 32'd0);
		busRead(AdrStat, q);
		checkVal("overrun flag", 32'(q[StatOvrBit]), 32'd0);
		waitStat(StatTxEmptyBit, 1'b1, "tx empty");
		endTest("overrun", errBase);

		errBase = errors;
		setFrame(Rows[3], 1'b0);
		randomByte(b);
		randomByte(b2);
		busWrite(AdrTrb, 4'b1111, {24'd0, b});
		fork
			captureTx(frameLen(Rows[3]), got);
			begin
				waitClocks(3 * BitClk);
				busWrite(AdrTrb, 4'b1111, {24'd0, b2});	// lands mid frame
			end
		join
		checkVal("txd_o frame", 32'(got), 32'(buildFrame(b, Rows[3])));
		// ignored byte must not follow as a second frame
		extra = 1'b0;
		for (int i = 0; i < 2 * BitClk; i++) begin
			waitClocks(1);
			if (!txd)
				extra = 1'b1;
		end
		assert (!extra) else begin
			$display("%0t ns: a second frame followed the write made while busy", $time);
			errors++;
		end
		waitStat(StatTxEmptyBit, 1'b0, "tx empty");
		endTest("write while busy", errBase);

		$display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- all.f
common/uartPkg.sv
verilog/baudGen.sv
verilog/uartRegs.sv
tx/uartTx.sv
rx/uartRx.sv
verilog/uartTop.sv
dv/uartProperties.sv
dv/uartTb.sv

//--- Makefile
TOP := uartTb

.PHONY: all lint clean

# build, run, and pass only when the pass line shows up
all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q "^Everything OK$$"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir
